// ==== rtl/bru_pkg.sv ====
package bru_pkg;

    // core data and address width
    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;

    // direct-mapped BTB, index from pc[5:2] and tag from pc[31:6]
    localparam int BTB_ENTRIES = 16;
    localparam int BTB_IDX_W   = 4;
    localparam int BTB_TAG_W   = 26;

    localparam logic [XLEN-1:0] RESET_PC = 32'h1c00_0000;

    // BL always links into r1
    localparam logic [REG_ADDR_W-1:0] LINK_REG = 5'd1;

    // execute-stage branch opcodes as delivered by decode
    typedef enum logic [3:0] {
        OP_NONE = 4'd0,
        OP_JIRL = 4'd3,
        OP_B    = 4'd4,
        OP_BL   = 4'd5,
        OP_BEQ  = 4'd6,
        OP_BNE  = 4'd7,
        OP_BLT  = 4'd8,
        OP_BGE  = 4'd9,
        OP_BLTU = 4'd10,
        OP_BGEU = 4'd11
    } branch_op_e;

    // category kept per BTB entry, decides whether the counter is consulted
    typedef enum logic [1:0] {
        CAT_COND     = 2'd1,  // conditional, follows the counter
        CAT_DIRECT   = 2'd2,  // B and BL
        CAT_INDIRECT = 2'd3   // JIRL, target may move between visits
    } br_category_e;

endpackage

// ==== rtl/branch_unit.sv ====
`timescale 1ns/1ps

module branch_unit (
    input  logic                                 br_en_in,
    input  logic              [bru_pkg::XLEN-1:0] pc,
    input  logic              [bru_pkg::XLEN-1:0] pc_next,
    input  bru_pkg::branch_op_e                   branch_op,
    input  logic        [bru_pkg::REG_ADDR_W-1:0] br_rd_addr_in,
    input  logic              [bru_pkg::XLEN-1:0] branch_sr0,
    input  logic              [bru_pkg::XLEN-1:0] branch_sr1,
    input  logic              [bru_pkg::XLEN-1:0] branch_imm,

    output logic              [bru_pkg::XLEN-1:0] br_rd_data,
    output logic        [bru_pkg::REG_ADDR_W-1:0] br_rd_addr_out,
    output logic                                 br_en_out,
    output logic                                 flush,
    output logic              [bru_pkg::XLEN-1:0] branch_addr_calculated,
    output logic              [bru_pkg::XLEN-1:0] ex_pc_tar,
    output logic                                 branch_valid,
    output logic                                 branch_status,
    output bru_pkg::br_category_e                 category
);

    logic [bru_pkg::XLEN-1:0] imm_sh;
    logic [bru_pkg::XLEN-1:0] pc_seq;
    logic                     src_eq;
    logic                     src_lt_s;
    logic                     src_lt_u;

    assign imm_sh = branch_imm << 2;  // offsets are word granular
    assign pc_seq = pc + 32'd4;

    // one comparator set shared by all six conditional ops
    assign src_eq   = (branch_sr0 == branch_sr1);
    assign src_lt_s = ($signed(branch_sr0) < $signed(branch_sr1));
    assign src_lt_u = (branch_sr0 < branch_sr1);

    always_comb begin
        case (branch_op)
            bru_pkg::OP_JIRL,
            bru_pkg::OP_B,
            bru_pkg::OP_BL:   branch_status = 1'b1;
            bru_pkg::OP_BEQ:  branch_status = src_eq;
            bru_pkg::OP_BNE:  branch_status = !src_eq;
            bru_pkg::OP_BLT:  branch_status = src_lt_s;
            bru_pkg::OP_BGE:  branch_status = !src_lt_s;
            bru_pkg::OP_BLTU: branch_status = src_lt_u;
            bru_pkg::OP_BGEU: branch_status = !src_lt_u;
            default:          branch_status = 1'b0;
        endcase
    end

    // JIRL is register relative, everything else is pc relative
    assign ex_pc_tar = (branch_op == bru_pkg::OP_JIRL) ? branch_sr0 + imm_sh : pc + imm_sh;

    assign branch_addr_calculated = branch_status ? ex_pc_tar : pc_seq;

    // decode carried pc_next from the fetch prediction, any mismatch is a mispredict
    assign flush        = br_en_in && (branch_addr_calculated != pc_next);
    assign branch_valid = br_en_in;

    always_comb begin
        case (branch_op)
            bru_pkg::OP_JIRL: category = bru_pkg::CAT_INDIRECT;
            bru_pkg::OP_B,
            bru_pkg::OP_BL:   category = bru_pkg::CAT_DIRECT;
            default:          category = bru_pkg::CAT_COND;
        endcase
    end

    // link write-back, only JIRL and BL name a destination
    always_comb begin
        br_rd_addr_out = '0;
        if (br_en_in) begin
            if (branch_op == bru_pkg::OP_JIRL) begin
                br_rd_addr_out = br_rd_addr_in;
            end else if (branch_op == bru_pkg::OP_BL) begin
                br_rd_addr_out = bru_pkg::LINK_REG;
            end
        end
    end

    assign br_en_out  = br_en_in;
    assign br_rd_data = br_en_in ? pc_seq : '0;  // a zero destination discards it

endmodule

// ==== rtl/btb.sv ====
`timescale 1ns/1ps

module btb (
    input  logic                                 clk,
    input  logic                                 arst_n,

    // lookup side, driven by the fetch PC register
    input  logic              [bru_pkg::XLEN-1:0] fetch_pc,
    output logic              [bru_pkg::XLEN-1:0] pred_pc,

    // update side, from the execute-stage branch unit
    input  logic                                 upd_en,
    input  logic              [bru_pkg::XLEN-1:0] upd_pc,
    input  logic              [bru_pkg::XLEN-1:0] upd_target,
    input  logic                                 upd_taken,
    input  bru_pkg::br_category_e                 upd_category
);

    localparam int IDX_LO = 2;
    localparam int IDX_HI = IDX_LO + bru_pkg::BTB_IDX_W - 1;
    localparam int TAG_LO = IDX_HI + 1;

    logic [bru_pkg::BTB_ENTRIES-1:0] entry_valid;
    logic [bru_pkg::BTB_TAG_W-1:0]   entry_tag    [bru_pkg::BTB_ENTRIES];
    logic [bru_pkg::XLEN-1:0]        entry_target [bru_pkg::BTB_ENTRIES];
    bru_pkg::br_category_e           entry_cat    [bru_pkg::BTB_ENTRIES];
    logic [1:0]                      entry_ctr    [bru_pkg::BTB_ENTRIES];

    logic [bru_pkg::BTB_IDX_W-1:0] rd_idx;
    logic [bru_pkg::BTB_TAG_W-1:0] rd_tag;
    logic                          rd_hit;
    logic                          rd_use_target;

    logic [bru_pkg::BTB_IDX_W-1:0] wr_idx;
    logic [bru_pkg::BTB_TAG_W-1:0] wr_tag;
    logic                          wr_hit;
    logic [1:0]                    wr_ctr_old;
    logic [1:0]                    wr_ctr_new;

    assign rd_idx = fetch_pc[IDX_HI:IDX_LO];
    assign rd_tag = fetch_pc[bru_pkg::XLEN-1:TAG_LO];

    assign rd_hit = entry_valid[rd_idx] && (entry_tag[rd_idx] == rd_tag);

    // unconditional kinds always jump, conditional ones need a taken-leaning counter
    assign rd_use_target = rd_hit &&
                           ((entry_cat[rd_idx] != bru_pkg::CAT_COND) || entry_ctr[rd_idx][1]);

    assign pred_pc = rd_use_target ? entry_target[rd_idx] : fetch_pc + 32'd4;

    assign wr_idx     = upd_pc[IDX_HI:IDX_LO];
    assign wr_tag     = upd_pc[bru_pkg::XLEN-1:TAG_LO];
    assign wr_hit     = entry_valid[wr_idx] && (entry_tag[wr_idx] == wr_tag);
    assign wr_ctr_old = entry_ctr[wr_idx];

    always_comb begin
        if (!wr_hit) begin
            // fresh entry starts weakly biased toward the first outcome
            wr_ctr_new = upd_taken ? 2'd2 : 2'd1;
        end else if (upd_taken) begin
            wr_ctr_new = (wr_ctr_old == 2'd3) ? 2'd3 : wr_ctr_old + 2'd1;
        end else begin
            wr_ctr_new = (wr_ctr_old == 2'd0) ? 2'd0 : wr_ctr_old - 2'd1;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            entry_valid <= '0;
        end else if (upd_en) begin
            entry_valid[wr_idx] <= 1'b1;
        end
    end

    // a conflicting branch simply evicts the old one
    always_ff @(posedge clk) begin
        if (upd_en) begin
            entry_tag[wr_idx]    <= wr_tag;
            entry_target[wr_idx] <= upd_target;
            entry_cat[wr_idx]    <= upd_category;
            entry_ctr[wr_idx]    <= wr_ctr_new;
        end
    end

endmodule

// ==== rtl/fetch_pc_gen.sv ====
`timescale 1ns/1ps

module fetch_pc_gen (
    input  logic                     clk,
    input  logic                     arst_n,
    input  logic                     fetch_stall,
    input  logic                     flush,
    input  logic [bru_pkg::XLEN-1:0] redirect_pc,  // resolved address from execute
    input  logic [bru_pkg::XLEN-1:0] pred_pc,      // BTB prediction for the current PC
    output logic [bru_pkg::XLEN-1:0] fetch_pc
);

    logic [bru_pkg::XLEN-1:0] pc_d;
    logic                     pc_load;

    // a redirect must land even when the front end is frozen
    always_comb begin
        if (flush) begin
            pc_d    = redirect_pc;
            pc_load = 1'b1;
        end else if (fetch_stall) begin
            pc_d    = fetch_pc;
            pc_load = 1'b0;
        end else begin
            pc_d    = pred_pc;
            pc_load = 1'b1;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            fetch_pc <= bru_pkg::RESET_PC;
        end else if (pc_load) begin
            fetch_pc <= pc_d;
        end
    end

endmodule

// ==== rtl/branch_ex_top.sv ====
`timescale 1ns/1ps

module branch_ex_top (
    input  logic                                 clk,
    input  logic                                 arst_n,

    input  logic                                 fetch_stall,
    output logic              [bru_pkg::XLEN-1:0] fetch_pc,
    output logic              [bru_pkg::XLEN-1:0] fetch_pc_pred,

    // execute-stage fields of the instruction being resolved
    input  logic                                 ex_valid,
    input  logic              [bru_pkg::XLEN-1:0] ex_pc,
    input  logic              [bru_pkg::XLEN-1:0] ex_pc_next,
    input  bru_pkg::branch_op_e                   ex_op,
    input  logic        [bru_pkg::REG_ADDR_W-1:0] ex_rd_addr,
    input  logic              [bru_pkg::XLEN-1:0] ex_sr0,
    input  logic              [bru_pkg::XLEN-1:0] ex_sr1,
    input  logic              [bru_pkg::XLEN-1:0] ex_imm,

    output logic                                 flush,
    output logic        [bru_pkg::REG_ADDR_W-1:0] br_rd_addr,
    output logic              [bru_pkg::XLEN-1:0] br_rd_data,
    output logic                                 br_rd_en,
    output logic                                 branch_taken,
    output logic              [bru_pkg::XLEN-1:0] branch_target
);

    logic [bru_pkg::XLEN-1:0] branch_addr_calculated;
    logic [bru_pkg::XLEN-1:0] ex_pc_tar;
    logic                     branch_status;
    logic                     branch_valid;
    bru_pkg::br_category_e    category;

    assign branch_target = branch_addr_calculated;
    assign branch_taken  = branch_status;

    branch_unit u_branch_unit (
        .br_en_in               (ex_valid),
        .pc                     (ex_pc),
        .pc_next                (ex_pc_next),
        .branch_op              (ex_op),
        .br_rd_addr_in          (ex_rd_addr),
        .branch_sr0             (ex_sr0),
        .branch_sr1             (ex_sr1),
        .branch_imm             (ex_imm),
        .br_rd_data             (br_rd_data),
        .br_rd_addr_out         (br_rd_addr),
        .br_en_out              (br_rd_en),
        .flush                  (flush),
        .branch_addr_calculated (branch_addr_calculated),
        .ex_pc_tar              (ex_pc_tar),
        .branch_valid           (branch_valid),
        .branch_status          (branch_status),
        .category               (category)
    );

    // trained with the raw target so not-taken conditionals still remember it
    btb u_btb (
        .clk          (clk),
        .arst_n       (arst_n),
        .fetch_pc     (fetch_pc),
        .pred_pc      (fetch_pc_pred),
        .upd_en       (branch_valid),
        .upd_pc       (ex_pc),
        .upd_target   (ex_pc_tar),
        .upd_taken    (branch_status),
        .upd_category (category)
    );

    fetch_pc_gen u_fetch_pc_gen (
        .clk         (clk),
        .arst_n      (arst_n),
        .fetch_stall (fetch_stall),
        .flush       (flush),
        .redirect_pc (branch_addr_calculated),
        .pred_pc     (fetch_pc_pred),
        .fetch_pc    (fetch_pc)
    );

endmodule

// ==== sim/branch_ex_properties.sv ====
`timescale 1ns/1ps

module branch_ex_properties (
    input logic                     clk,
    input logic                     arst_n,
    input logic                     ex_valid,
    input logic                     flush,
    input logic [bru_pkg::XLEN-1:0] fetch_pc,
    input logic [bru_pkg::XLEN-1:0] branch_target
);

    int fail_count = 0;

    // only a resolving instruction may redirect fetch
    a_flush_needs_valid: assert property (
        @(posedge clk) disable iff (!arst_n) flush |-> ex_valid
    ) else begin
        $error("flush raised while ex_valid is low");
        fail_count++;
    end

    a_reset_pc: assert property (
        @(posedge clk) $rose(arst_n) |-> (fetch_pc == bru_pkg::RESET_PC)
    ) else begin
        $error("fetch_pc is not the reset address after reset release");
        fail_count++;
    end

    a_flush_redirect: assert property (
        @(posedge clk) disable iff (!arst_n) flush |=> (fetch_pc == $past(branch_target))
    ) else begin
        $error("fetch_pc did not follow the flush target");
        fail_count++;
    end

endmodule

bind branch_ex_top branch_ex_properties u_props (
    .clk           (clk),
    .arst_n        (arst_n),
    .ex_valid      (ex_valid),
    .flush         (flush),
    .fetch_pc      (fetch_pc),
    .branch_target (branch_target)
);

// ==== sim/branch_ex_tb.sv ====
`timescale 1ns/1ps

module branch_ex_tb;

    localparam int CLK_PERIOD   = 40;
    localparam int RESET_CYCLES = 10;
    localparam int NUM_TESTS    = 5;

    logic                              clk;
    logic                              arst_n;
    logic                              fetch_stall;
    logic                              ex_valid;
    logic [bru_pkg::XLEN-1:0]          ex_pc;
    logic [bru_pkg::XLEN-1:0]          ex_pc_next;
    bru_pkg::branch_op_e               ex_op;
    logic [bru_pkg::REG_ADDR_W-1:0]    ex_rd_addr;
    logic [bru_pkg::XLEN-1:0]          ex_sr0;
    logic [bru_pkg::XLEN-1:0]          ex_sr1;
    logic [bru_pkg::XLEN-1:0]          ex_imm;

    logic [bru_pkg::XLEN-1:0]          fetch_pc;
    logic [bru_pkg::XLEN-1:0]          fetch_pc_pred;
    logic                              flush;
    logic [bru_pkg::REG_ADDR_W-1:0]    br_rd_addr;
    logic [bru_pkg::XLEN-1:0]          br_rd_data;
    logic                              br_rd_en;
    logic                              branch_taken;
    logic [bru_pkg::XLEN-1:0]          branch_target;

    int seed   = 32'h3879_b61e;
    int checks = 0;
    int errors = 0;

    branch_ex_top dut0 (
        .clk           (clk),
        .arst_n        (arst_n),
        .fetch_stall   (fetch_stall),
        .fetch_pc      (fetch_pc),
        .fetch_pc_pred (fetch_pc_pred),
        .ex_valid      (ex_valid),
        .ex_pc         (ex_pc),
        .ex_pc_next    (ex_pc_next),
        .ex_op         (ex_op),
        .ex_rd_addr    (ex_rd_addr),
        .ex_sr0        (ex_sr0),
        .ex_sr1        (ex_sr1),
        .ex_imm        (ex_imm),
        .flush         (flush),
        .br_rd_addr    (br_rd_addr),
        .br_rd_data    (br_rd_data),
        .br_rd_en      (br_rd_en),
        .branch_taken  (branch_taken),
        .branch_target (branch_target)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic check_addr(input string name, input logic [bru_pkg::XLEN-1:0] got,
                              input logic [bru_pkg::XLEN-1:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[ERROR] %0t %s: got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[ERROR] %0t %s: got %b expected %b", $time, name, got, exp);
        end
    endtask

    task automatic check_reg(input string name, input logic [bru_pkg::REG_ADDR_W-1:0] got,
                             input logic [bru_pkg::REG_ADDR_W-1:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[ERROR] %0t %s: got %0d expected %0d", $time, name, got, exp);
        end
    endtask

    task automatic check_category(input string name, input bru_pkg::br_category_e got,
                                  input bru_pkg::br_category_e exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[ERROR] %0t %s: got %0d expected %0d", $time, name, got, exp);
        end
    endtask

    task automatic report_test(input string name, input int err_start);
        $display("test %-18s %s (%0d errors)", name,
                 (errors == err_start) ? "ok" : "failed", errors - err_start);
    endtask

    // independent model of the taken rule, signed order via the flipped sign bit
    function automatic logic taken_model(input bru_pkg::branch_op_e op,
                                         input logic [bru_pkg::XLEN-1:0] a,
                                         input logic [bru_pkg::XLEN-1:0] b);
        logic [bru_pkg::XLEN-1:0] as;
        logic [bru_pkg::XLEN-1:0] bs;
        as = a ^ 32'h8000_0000;
        bs = b ^ 32'h8000_0000;
        case (op)
            bru_pkg::OP_BEQ:  taken_model = (a == b);
            bru_pkg::OP_BNE:  taken_model = (a != b);
            bru_pkg::OP_BLT:  taken_model = (as < bs);
            bru_pkg::OP_BGE:  taken_model = (as >= bs);
            bru_pkg::OP_BLTU: taken_model = (a < b);
            bru_pkg::OP_BGEU: taken_model = (a >= b);
            default:          taken_model = 1'b1;
        endcase
    endfunction

    function automatic bru_pkg::branch_op_e cond_op(input int i);
        case (i)
            0:       cond_op = bru_pkg::OP_BEQ;
            1:       cond_op = bru_pkg::OP_BNE;
            2:       cond_op = bru_pkg::OP_BLT;
            3:       cond_op = bru_pkg::OP_BGE;
            4:       cond_op = bru_pkg::OP_BLTU;
            default: cond_op = bru_pkg::OP_BGEU;
        endcase
    endfunction

    // presents one instruction to execute and returns at the following falling edge
    task automatic resolve(input bru_pkg::branch_op_e op,
                           input logic [bru_pkg::XLEN-1:0] pc,
                           input logic [bru_pkg::XLEN-1:0] pc_next,
                           input logic [bru_pkg::XLEN-1:0] sr0,
                           input logic [bru_pkg::XLEN-1:0] sr1,
                           input logic [bru_pkg::XLEN-1:0] imm,
                           input logic [bru_pkg::REG_ADDR_W-1:0] rd);
        @(posedge clk);
        ex_valid   <= 1'b1;
        ex_op      <= op;
        ex_pc      <= pc;
        ex_pc_next <= pc_next;
        ex_sr0     <= sr0;
        ex_sr1     <= sr1;
        ex_imm     <= imm;
        ex_rd_addr <= rd;
        @(negedge clk);
    endtask

    task automatic go_idle();
        @(posedge clk);
        ex_valid <= 1'b0;
        @(negedge clk);
    endtask

    task automatic set_stall(input logic stall);
        @(posedge clk);
        ex_valid    <= 1'b0;
        fetch_stall <= stall;
        @(negedge clk);
    endtask

    task automatic reset_and_advance();
        logic [bru_pkg::XLEN-1:0] exp_pc;
        int                       err_start;
        err_start = errors;
        exp_pc = 32'h1c00_0000;
        @(negedge clk);
        check_addr("fetch_pc", fetch_pc, exp_pc);
        check_addr("fetch_pc_pred", fetch_pc_pred, exp_pc + 32'd4);
        check_bit("flush", flush, 1'b0);
        check_bit("br_rd_en", br_rd_en, 1'b0);
        for (int i = 0; i < 4; i++) begin
            @(negedge clk);
            exp_pc = exp_pc + 32'd4;
            check_addr("fetch_pc", fetch_pc, exp_pc);
        end
        set_stall(1'b1);
        exp_pc = exp_pc + 32'd4;  // the edge that raises the stall still advances
        for (int i = 0; i < 3; i++) begin
            check_addr("fetch_pc", fetch_pc, exp_pc);
            @(negedge clk);
        end
        set_stall(1'b0);
        report_test("reset_and_advance", err_start);
    endtask

    task automatic condition_eval();
        bru_pkg::branch_op_e      op;
        logic [bru_pkg::XLEN-1:0] a;
        logic [bru_pkg::XLEN-1:0] b;
        logic [bru_pkg::XLEN-1:0] pc;
        logic [bru_pkg::XLEN-1:0] imm;
        logic [bru_pkg::XLEN-1:0] exp_addr;
        logic                     exp_taken;
        int                       err_start;
        err_start = errors;
        for (int i = 0; i < 6; i++) begin
            op = cond_op(i);
            for (int j = 0; j < 11; j++) begin
                case (j)
                    0: begin
                        a = 32'h1234_5678;
                        b = 32'h1234_5678;
                    end
                    1: begin
                        a = 32'h7fff_ffff;
                        b = 32'h8000_0000;
                    end
                    2: begin
                        a = 32'h8000_0000;
                        b = 32'h7fff_ffff;
                    end
                    3: begin
                        a = 32'h0000_0000;
                        b = 32'hffff_ffff;
                    end
                    4: begin
                        a = 32'hffff_ffff;
                        b = 32'h0000_0000;
                    end
                    default: begin
                        a = $random(seed);
                        b = $random(seed);
                    end
                endcase
                pc  = $random(seed) & 32'hffff_fffc;
                imm = $random(seed) % 256;
                exp_taken = taken_model(op, a, b);
                exp_addr  = exp_taken ? pc + (imm << 2) : pc + 32'd4;
                resolve(op, pc, pc + 32'd4, a, b, imm, 5'd7);
                check_bit("branch_taken", branch_taken, exp_taken);
                check_addr("branch_target", branch_target, exp_addr);
                check_bit("flush", flush, exp_addr != pc + 32'd4);
                check_reg("br_rd_addr", br_rd_addr, 5'd0);
                check_bit("br_rd_en", br_rd_en, 1'b1);
                check_category("category", dut0.u_branch_unit.category, bru_pkg::CAT_COND);
            end
        end
        go_idle();
        report_test("condition_eval", err_start);
    endtask

    task automatic jumps_and_link();
        bru_pkg::branch_op_e            op;
        bru_pkg::br_category_e          exp_cat;
        logic [bru_pkg::XLEN-1:0]       pc;
        logic [bru_pkg::XLEN-1:0]       sr0;
        logic [bru_pkg::XLEN-1:0]       imm;
        logic [bru_pkg::XLEN-1:0]       rnd;
        logic [bru_pkg::XLEN-1:0]       exp_addr;
        logic [bru_pkg::REG_ADDR_W-1:0] rd;
        logic [bru_pkg::REG_ADDR_W-1:0] exp_rd;
        int                             err_start;
        err_start = errors;
        for (int k = 0; k < 12; k++) begin
            case (k % 3)
                0:       op = bru_pkg::OP_JIRL;
                1:       op = bru_pkg::OP_B;
                default: op = bru_pkg::OP_BL;
            endcase
            pc  = $random(seed) & 32'hffff_fffc;
            sr0 = $random(seed);
            imm = $random(seed) % 4096;
            rnd = $random(seed);
            rd  = rnd[4:0];
            if (op == bru_pkg::OP_JIRL) begin
                exp_addr = sr0 + (imm << 2);
                exp_rd   = rd;
                exp_cat  = bru_pkg::CAT_INDIRECT;
            end else begin
                exp_addr = pc + (imm << 2);
                exp_rd   = (op == bru_pkg::OP_BL) ? 5'd1 : 5'd0;
                exp_cat  = bru_pkg::CAT_DIRECT;
            end
            resolve(op, pc, exp_addr, sr0, 32'h0, imm, rd);
            check_bit("branch_taken", branch_taken, 1'b1);
            check_addr("branch_target", branch_target, exp_addr);
            check_bit("flush", flush, 1'b0);
            check_reg("br_rd_addr", br_rd_addr, exp_rd);
            check_addr("br_rd_data", br_rd_data, pc + 32'd4);
            check_bit("br_rd_en", br_rd_en, 1'b1);
            check_category("category", dut0.u_branch_unit.category, exp_cat);
        end
        go_idle();
        check_bit("br_rd_en", br_rd_en, 1'b0);
        check_bit("flush", flush, 1'b0);
        report_test("jumps_and_link", err_start);
    endtask

    task automatic flush_redirect();
        logic [bru_pkg::XLEN-1:0] pc;
        logic [bru_pkg::XLEN-1:0] tgt;
        int                       err_start;
        err_start = errors;
        pc  = 32'h2000_0040;
        tgt = pc + (32'h10 << 2);
        resolve(bru_pkg::OP_BNE, pc, tgt, 32'h1, 32'h2, 32'h10, 5'd0);
        check_bit("flush", flush, 1'b0);
        check_addr("branch_target", branch_target, tgt);
        set_stall(1'b1);
        // taken branch that decode assumed would fall through
        resolve(bru_pkg::OP_BNE, pc, pc + 32'd4, 32'h1, 32'h2, 32'h10, 5'd0);
        check_bit("flush", flush, 1'b1);
        go_idle();
        check_addr("fetch_pc", fetch_pc, tgt);
        @(negedge clk);
        check_addr("fetch_pc", fetch_pc, tgt);
        // not taken branch that decode assumed would jump
        resolve(bru_pkg::OP_BEQ, pc, tgt, 32'h1, 32'h2, 32'h10, 5'd0);
        check_bit("flush", flush, 1'b1);
        check_addr("branch_target", branch_target, pc + 32'd4);
        go_idle();
        check_addr("fetch_pc", fetch_pc, pc + 32'd4);
        set_stall(1'b0);
        report_test("flush_redirect", err_start);
    endtask

    task automatic btb_learning();
        logic [bru_pkg::XLEN-1:0] x_pc;
        logic [bru_pkg::XLEN-1:0] x_tgt;
        logic [bru_pkg::XLEN-1:0] q_pc;
        logic [bru_pkg::XLEN-1:0] y_pc;
        logic [bru_pkg::XLEN-1:0] y_tgt;
        logic [4:0]               outcome;
        logic [4:0]               use_target;
        logic                     tk;
        int                       err_start;
        err_start = errors;
        x_pc       = 32'h1c00_0100;  // index 0
        x_tgt      = x_pc + (32'h40 << 2);
        q_pc       = 32'h1c00_0404;  // index 1, only used to steer fetch
        y_pc       = 32'h1c00_0208;  // index 2
        y_tgt      = y_pc + (32'h20 << 2);
        outcome    = 5'b00110;
        use_target = 5'b01110;  // counter runs 1, 2, 3, 2, 1 and only 2 and 3 follow the target
        resolve(bru_pkg::OP_B, x_pc, x_tgt, 32'h0, 32'h0, 32'h40, 5'd0);
        check_bit("flush", flush, 1'b0);
        set_stall(1'b1);
        resolve(bru_pkg::OP_JIRL, q_pc, q_pc + 32'd4, x_pc, 32'h0, 32'h0, 5'd0);
        check_bit("flush", flush, 1'b1);
        go_idle();
        check_addr("fetch_pc", fetch_pc, x_pc);
        check_addr("fetch_pc_pred", fetch_pc_pred, x_tgt);
        resolve(bru_pkg::OP_JIRL, q_pc, q_pc + 32'd4, y_pc, 32'h0, 32'h0, 5'd0);
        go_idle();
        check_addr("fetch_pc", fetch_pc, y_pc);
        check_addr("fetch_pc_pred", fetch_pc_pred, y_pc + 32'd4);
        for (int i = 0; i < 5; i++) begin
            tk = outcome[i];
            resolve(bru_pkg::OP_BEQ, y_pc, tk ? y_tgt : y_pc + 32'd4,
                    32'h55, tk ? 32'h55 : 32'h56, 32'h20, 5'd0);
            check_bit("flush", flush, 1'b0);
            go_idle();
            check_addr("fetch_pc", fetch_pc, y_pc);
            check_addr("fetch_pc_pred", fetch_pc_pred, use_target[i] ? y_tgt : y_pc + 32'd4);
        end
        set_stall(1'b0);
        report_test("btb_learning", err_start);
    endtask

    // watchdog sized from the test count
    initial begin
        #(NUM_TESTS * 200 * CLK_PERIOD);
        $display("timeout after %0d cycles, the tests did not complete", NUM_TESTS * 200);
        $display("Simulation finished: FAIL");
        $finish;
    end

    initial begin
        clk         = 1'b0;
        arst_n      = 1'b0;
        fetch_stall = 1'b0;
        ex_valid    = 1'b0;
        ex_pc       = '0;
        ex_pc_next  = '0;
        ex_op       = bru_pkg::OP_NONE;
        ex_rd_addr  = '0;
        ex_sr0      = '0;
        ex_sr1      = '0;
        ex_imm      = '0;
        repeat (RESET_CYCLES) @(posedge clk);
        arst_n <= 1'b1;
        reset_and_advance();
        condition_eval();
        jumps_and_link();
        flush_redirect();
        btb_learning();
        errors = errors + dut0.u_props.fail_count;
        $display("checks: %0d, errors: %0d, assertion failures: %0d",
                 checks, errors, dut0.u_props.fail_count);
        if (errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

// ==== branch_ex.f ====
rtl/bru_pkg.sv
rtl/branch_unit.sv
rtl/btb.sv
rtl/fetch_pc_gen.sv
rtl/branch_ex_top.sv
sim/branch_ex_properties.sv
sim/branch_ex_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# builds the branch_ex testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
    --top-module branch_ex_tb \
    --Mdir obj_dir \
    -f branch_ex.f
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

out=$(./obj_dir/Vbranch_ex_tb 2>&1)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$out" | grep -qx "Simulation finished: PASS"; then
    exit 0
fi
echo "pass message not found in simulation output"
exit 1
